//--- source/dff_axi_settings.svh
// bus width and word-address constants, included by the package and the RTL modules
`ifndef DFF_AXI_SETTINGS_SVH
`define DFF_AXI_SETTINGS_SVH

// AXI4-Lite address bus width
`define DFF_AXI_ADDR_WIDTH 32

// AXI4-Lite data bus width
`define DFF_AXI_DATA_WIDTH 32

// byte address to word index
`define DFF_AXI_ADDR_LSB 2

// one strobe bit per data byte
`define DFF_AXI_STRB_WIDTH (`DFF_AXI_DATA_WIDTH / 8)

`endif

//--- source/dff_axi_pkg.sv
// shared enums and request/response structs for the AXI4-Lite flip-flop slave
`include "dff_axi_settings.svh"

package dff_axi_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        ADDR = 2'b01,
        DATA = 2'b10,
        RESP = 2'b11
    } chan_state_e;

    // word index from address bits 3:2
    typedef enum logic [1:0] {
        REG_D     = 2'd0,
        REG_Q     = 2'd1,
        REG_RSVD2 = 2'd2,
        REG_RSVD3 = 2'd3
    } reg_sel_e;

    typedef struct packed {
        reg_sel_e sel;
        logic     strb0;
        logic     data0;
        logic     en;    // one-cycle write strobe
    } reg_wr_req_t;

    typedef struct packed {
        axi_resp_e resp;
    } reg_wr_rsp_t;

    typedef struct packed {
        reg_sel_e sel;
    } reg_rd_req_t;

    typedef struct packed {
        logic [`DFF_AXI_DATA_WIDTH-1:0] data;
        axi_resp_e                      resp;
    } reg_rd_rsp_t;

endpackage

//--- source/axi_write_channel.sv
// AXI4-Lite write sequencing, turns each AW/W/B transaction into one register write request
`timescale 1ns/1ps
`include "dff_axi_settings.svh"

module axi_write_channel (
    input  logic                            axi_aclk,
    input  logic                            axi_aresetn,
    input  logic [`DFF_AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`DFF_AXI_DATA_WIDTH-1:0]  wdata,
    input  logic [`DFF_AXI_STRB_WIDTH-1:0]  wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output dff_axi_pkg::axi_resp_e          bresp,
    output logic                            bvalid,
    input  logic                            bready,
    output dff_axi_pkg::reg_wr_req_t        wr_req,
    input  dff_axi_pkg::reg_wr_rsp_t        wr_rsp
);
    import dff_axi_pkg::*;

    chan_state_e state;
    reg_sel_e    wr_sel;
    logic        wr_en;
    logic        wr_data0;
    logic        wr_strb0;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state   <= IDLE;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= OKAY;
            wr_en   <= 1'b0;
            wr_sel  <= REG_D;
        end else begin
            case (state)
                IDLE: begin
                    if (awvalid) begin
                        awready <= 1'b1;
                        wr_sel  <= reg_sel_e'(awaddr[`DFF_AXI_ADDR_LSB +: 2]);
                        state   <= ADDR;
                    end
                end
                ADDR: begin
                    awready <= 1'b0; // master holds awvalid through this cycle
                    state   <= DATA;
                end
                DATA: begin
                    if (!wready) begin
                        wready <= 1'b1;
                    end else if (wvalid) begin
                        wready <= 1'b0;
                        wr_en  <= 1'b1;
                        bresp  <= wr_rsp.resp; // bank decides writability
                        state  <= RESP;
                    end
                end
                RESP: begin
                    if (wr_en) begin
                        wr_en  <= 1'b0; // register updates on this edge
                        bvalid <= 1'b1;
                    end else if (bready) begin
                        bvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // write payload, only bit 0 and strobe 0 matter
    always_ff @(posedge axi_aclk) begin
        if (state == DATA && wready && wvalid) begin
            wr_data0 <= wdata[0];
            wr_strb0 <= wstrb[0];
        end
    end

    assign wr_req = '{sel: wr_sel, strb0: wr_strb0, data0: wr_data0, en: wr_en};

    awready_single_cycle: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        awready |=> !awready
    );

    bvalid_held_until_bready: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

//--- source/axi_read_channel.sv
// AXI4-Lite read sequencing, one register read per AR/R transaction
`timescale 1ns/1ps
`include "dff_axi_settings.svh"

module axi_read_channel (
    input  logic                            axi_aclk,
    input  logic                            axi_aresetn,
    input  logic [`DFF_AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [`DFF_AXI_DATA_WIDTH-1:0]  rdata,
    output dff_axi_pkg::axi_resp_e          rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output dff_axi_pkg::reg_rd_req_t        rd_req,
    input  dff_axi_pkg::reg_rd_rsp_t        rd_rsp
);
    import dff_axi_pkg::*;

    chan_state_e state;
    reg_sel_e    rd_sel;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state   <= IDLE;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= OKAY;
            rd_sel  <= REG_D;
        end else begin
            case (state)
                IDLE: begin
                    if (arvalid) begin
                        arready <= 1'b1;
                        rd_sel  <= reg_sel_e'(araddr[`DFF_AXI_ADDR_LSB +: 2]);
                        state   <= ADDR;
                    end
                end
                ADDR: begin
                    arready <= 1'b0;
                    state   <= DATA;
                end
                DATA: begin
                    if (!rvalid) begin
                        // sample the bank once, then hold for the master
                        rvalid <= 1'b1;
                        rdata  <= rd_rsp.data;
                        rresp  <= rd_rsp.resp;
                    end else if (rready) begin
                        rvalid <= 1'b0;
                        state  <= IDLE;
                    end
                end
                default: state <= IDLE; // no RESP phase on reads
            endcase
        end
    end

    assign rd_req = '{sel: rd_sel};

    rdata_stable_while_stalled: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp)
    );

endmodule

//--- source/dff_regbank.sv
// D flip-flop register bank with two-stage output pipeline, serves both AXI channels
`timescale 1ns/1ps
`include "dff_axi_settings.svh"

module dff_regbank (
    input  logic                     axi_aclk,
    input  logic                     axi_aresetn,
    input  dff_axi_pkg::reg_wr_req_t wr_req,
    output dff_axi_pkg::reg_wr_rsp_t wr_rsp,
    input  dff_axi_pkg::reg_rd_req_t rd_req,
    output dff_axi_pkg::reg_rd_rsp_t rd_rsp
);
    import dff_axi_pkg::*;

    logic       d_reg;
    logic       d_pipe;
    logic       q_reg;
    logic [1:0] live_cnt; // cycles since reset release, saturating

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            d_reg  <= 1'b0;
            d_pipe <= 1'b0;
            q_reg  <= 1'b0;
        end else begin
            if (wr_req.en && wr_req.sel == REG_D && wr_req.strb0) begin
                d_reg <= wr_req.data0;
            end
            d_pipe <= d_reg;
            q_reg  <= d_pipe;
        end
    end

    // only register 0 accepts writes
    assign wr_rsp.resp = (wr_req.sel == REG_D) ? OKAY : SLVERR;

    always_comb begin
        case (rd_req.sel)
            REG_D: begin
                rd_rsp.data = {{(`DFF_AXI_DATA_WIDTH-1){1'b0}}, d_reg};
                rd_rsp.resp = OKAY;
            end
            REG_Q: begin
                rd_rsp.data = {{(`DFF_AXI_DATA_WIDTH-1){1'b0}}, q_reg};
                rd_rsp.resp = OKAY;
            end
            default: begin
                rd_rsp.data = '0;
                rd_rsp.resp = SLVERR;
            end
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            live_cnt <= 2'd0;
        end else if (live_cnt != 2'd3) begin
            live_cnt <= live_cnt + 2'd1;
        end
    end

    q_follows_d_two_cycles: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        (live_cnt == 2'd3) |-> (q_reg == $past(d_reg, 2))
    );

endmodule

//--- source/dff_axi_top.sv
// AXI4-Lite slave top exposing one D flip-flop as register 0 (input) and register 1 (output)
`timescale 1ns/1ps
`include "dff_axi_settings.svh"

module dff_axi_top (
    input  logic                            axi_aclk,
    input  logic                            axi_aresetn,
    input  logic [`DFF_AXI_ADDR_WIDTH-1:0]  s_axi_awaddr,
    input  logic                            s_axi_awvalid,
    output logic                            s_axi_awready,
    input  logic [`DFF_AXI_DATA_WIDTH-1:0]  s_axi_wdata,
    input  logic [`DFF_AXI_STRB_WIDTH-1:0]  s_axi_wstrb,
    input  logic                            s_axi_wvalid,
    output logic                            s_axi_wready,
    output dff_axi_pkg::axi_resp_e          s_axi_bresp,
    output logic                            s_axi_bvalid,
    input  logic                            s_axi_bready,
    input  logic [`DFF_AXI_ADDR_WIDTH-1:0]  s_axi_araddr,
    input  logic                            s_axi_arvalid,
    output logic                            s_axi_arready,
    output logic [`DFF_AXI_DATA_WIDTH-1:0]  s_axi_rdata,
    output dff_axi_pkg::axi_resp_e          s_axi_rresp,
    output logic                            s_axi_rvalid,
    input  logic                            s_axi_rready
);
    import dff_axi_pkg::*;

    reg_wr_req_t wr_req;
    reg_wr_rsp_t wr_rsp;
    reg_rd_req_t rd_req;
    reg_rd_rsp_t rd_rsp;

    axi_write_channel u_wr_chan (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .awaddr      (s_axi_awaddr),
        .awvalid     (s_axi_awvalid),
        .awready     (s_axi_awready),
        .wdata       (s_axi_wdata),
        .wstrb       (s_axi_wstrb),
        .wvalid      (s_axi_wvalid),
        .wready      (s_axi_wready),
        .bresp       (s_axi_bresp),
        .bvalid      (s_axi_bvalid),
        .bready      (s_axi_bready),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp)
    );

    axi_read_channel u_rd_chan (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .araddr      (s_axi_araddr),
        .arvalid     (s_axi_arvalid),
        .arready     (s_axi_arready),
        .rdata       (s_axi_rdata),
        .rresp       (s_axi_rresp),
        .rvalid      (s_axi_rvalid),
        .rready      (s_axi_rready),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp)
    );

    dff_regbank u_regbank (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_req      (wr_req),
        .wr_rsp      (wr_rsp),
        .rd_req      (rd_req),
        .rd_rsp      (rd_rsp)
    );

endmodule

//--- testbench/tb_dff_axi.sv
// simulation top that drives and checks the AXI4-Lite flip-flop slave
`timescale 1ns/1ps
`include "dff_axi_settings.svh"

module tb_dff_axi;
    import dff_axi_pkg::*;

    localparam int HANDSHAKE_LIMIT = 20; // cycles before a missing ready/valid counts as a hang

    logic                           axi_aclk;
    logic                           axi_aresetn;
    logic [`DFF_AXI_ADDR_WIDTH-1:0] s_axi_awaddr;
    logic [`DFF_AXI_ADDR_WIDTH-1:0] s_axi_araddr;
    logic [`DFF_AXI_DATA_WIDTH-1:0] s_axi_wdata;
    logic [`DFF_AXI_DATA_WIDTH-1:0] s_axi_rdata;
    logic [`DFF_AXI_STRB_WIDTH-1:0] s_axi_wstrb;
    logic                           s_axi_awvalid;
    logic                           s_axi_awready;
    logic                           s_axi_wvalid;
    logic                           s_axi_wready;
    logic                           s_axi_bvalid;
    logic                           s_axi_bready;
    logic                           s_axi_arvalid;
    logic                           s_axi_arready;
    logic                           s_axi_rvalid;
    logic                           s_axi_rready;
    axi_resp_e                      s_axi_bresp;
    axi_resp_e                      s_axi_rresp;

    axi_resp_e   wr_resp_seen;
    axi_resp_e   rd_resp_seen;
    logic [31:0] rd_data_seen;
    logic        bvalid_at_ar; // write response still pending when AR was accepted
    logic        model_d;     // expected content of register 0
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          pass_count;
    int          fail_count;

    dff_axi_top DUT (.*);

    initial begin
        axi_aclk = 1'b0;
        forever #20 axi_aclk = ~axi_aclk;
    end

    initial begin
        #(6 * 40 * 12 * 40);
        $display("watchdog expired, the run did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

    bresp_held_while_stalled: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp)
    ) else begin
        $display("%s: BVALID or BRESP changed while the write response was stalled", test_name);
        errors++;
    end

    rdata_held_while_stalled: assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
            && $stable(s_axi_rresp)
    ) else begin
        $display("%s: RVALID, RDATA or RRESP changed while the read was stalled", test_name);
        errors++;
    end

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge axi_aclk);
            #2;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_hang(input string what);
        $display("%s: %s did not arrive within %0d cycles", test_name, what, HANDSHAKE_LIMIT);
        errors++;
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int stall);
        int n;
        s_axi_awaddr  = addr;
        s_axi_awvalid = 1'b1;
        s_axi_wdata   = data;
        s_axi_wstrb   = strb;
        s_axi_wvalid  = 1'b1;
        for (n = 0; !s_axi_awready && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
        if (!s_axi_awready) report_hang("AWREADY");
        idle_cycles(1); // AW accepted on this edge
        s_axi_awvalid = 1'b0;
        for (n = 0; !s_axi_wready && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
        if (!s_axi_wready) report_hang("WREADY");
        if (addr[`DFF_AXI_ADDR_LSB +: 2] == 2'd0 && strb[0]) model_d = data[0];
        idle_cycles(1);
        s_axi_wvalid = 1'b0;
        for (n = 0; !s_axi_bvalid && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
        if (!s_axi_bvalid) report_hang("BVALID");
        wr_resp_seen = s_axi_bresp;
        idle_cycles(stall); // hold off the master side
        s_axi_bready = 1'b1;
        idle_cycles(1);
        s_axi_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int stall);
        int n;
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        for (n = 0; !s_axi_arready && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
        if (!s_axi_arready) report_hang("ARREADY");
        bvalid_at_ar = s_axi_bvalid;
        idle_cycles(1);
        s_axi_arvalid = 1'b0;
        for (n = 0; !s_axi_rvalid && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
        if (!s_axi_rvalid) report_hang("RVALID");
        rd_data_seen = s_axi_rdata;
        rd_resp_seen = s_axi_rresp;
        idle_cycles(stall);
        s_axi_rready = 1'b1;
        idle_cycles(1);
        s_axi_rready = 1'b0;
    endtask

    task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                   input logic [3:0] strb, input int stall);
        axi_write(addr, data, strb, stall);
        check_value("BRESP", (addr[`DFF_AXI_ADDR_LSB +: 2] == 2'd0) ? 32'(OKAY) : 32'(SLVERR),
                    32'(wr_resp_seen));
    endtask

    // word 1 matches the model only once the pipeline has settled
    task automatic read_and_check(input logic [31:0] addr, input int stall);
        logic [1:0] word;
        word = addr[`DFF_AXI_ADDR_LSB +: 2];
        axi_read(addr, stall);
        check_value("RDATA", (word < 2'd2) ? {31'd0, model_d} : 32'd0, rd_data_seen);
        check_value("RRESP", (word < 2'd2) ? 32'(OKAY) : 32'(SLVERR), 32'(rd_resp_seen));
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            pass_count++;
            $display("test %s: passed", test_name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        int wr_stall;
        int rd_stall;
        logic [31:0] wr_data;
        void'($urandom(32'h3da8_073d));
        s_axi_awaddr    = '0;
        s_axi_araddr    = '0;
        s_axi_wdata     = '0;
        s_axi_wstrb     = '0;
        s_axi_awvalid   = 1'b0;
        s_axi_wvalid    = 1'b0;
        s_axi_bready    = 1'b0;
        s_axi_arvalid   = 1'b0;
        s_axi_rready    = 1'b0;
        bvalid_at_ar    = 1'b0;
        model_d         = 1'b0;
        errors          = 0;
        errors_at_start = 0;
        pass_count      = 0;
        fail_count      = 0;
        test_name   = "reset";
        axi_aresetn = 1'b0;
        idle_cycles(5);
        axi_aresetn = 1'b1;

        start_test("after_reset");
        check_value("ready and valid outputs", 32'd0, {27'd0, s_axi_awready, s_axi_wready,
                    s_axi_bvalid, s_axi_arready, s_axi_rvalid});
        read_and_check(32'd0, 0);
        read_and_check(32'd4, 0);
        finish_test();

        start_test("write_readback");
        for (int i = 0; i < 20; i++) begin
            write_and_check(32'd0, $urandom, 4'hF, 0);
            read_and_check(32'd0, 0);
        end
        finish_test();

        start_test("output_follows_input");
        for (int i = 0; i < 20; i++) begin
            write_and_check(32'd0, $urandom, 4'hF, 0);
            idle_cycles(3);
            read_and_check(32'd4, 0);
        end
        finish_test();

        start_test("strobe_and_alias");
        write_and_check(32'd0, {31'd0, ~model_d}, 4'b1110, 0); // strobe 0 clear so no update
        read_and_check(32'd0, 0);
        write_and_check(32'd16, {31'd0, ~model_d}, 4'b0001, 0);
        read_and_check(32'd16, 0);
        idle_cycles(3);
        read_and_check(32'd4, 0);
        finish_test();

        start_test("error_responses");
        for (int a = 4; a <= 12; a += 4) write_and_check(32'(a), {31'd0, ~model_d}, 4'hF, 0);
        idle_cycles(3);
        for (int a = 0; a <= 12; a += 4) read_and_check(32'(a), 0);
        finish_test();

        start_test("back_pressure");
        for (int i = 0; i < 10; i++) begin
            wr_stall = $urandom_range(8, 1);
            rd_stall = $urandom_range(8, 1);
            wr_data  = $urandom;
            fork
                write_and_check(32'd0, wr_data, 4'hF, wr_stall);
                begin
                    int n;
                    for (n = 0; !s_axi_bvalid && n < HANDSHAKE_LIMIT; n++) idle_cycles(1);
                    read_and_check(32'd0, rd_stall); // runs while BREADY is held low
                    check_value("BVALID at AR handshake", 32'd1, {31'd0, bvalid_at_ar});
                end
            join
            idle_cycles(3);
            read_and_check(32'd4, rd_stall);
        end
        finish_test();

        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/dff_axi_pkg.sv
source/axi_write_channel.sv
source/axi_read_channel.sv
source/dff_regbank.sv
source/dff_axi_top.sv
testbench/tb_dff_axi.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_dff_axi -o Vtb_dff_axi

output="$(./obj_dir/Vtb_dff_axi)"
echo "$output"

if grep -qx "TESTS PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi
